//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // alu control, bit 3 picks sub, arithmetic shift or unsigned compare
    localparam logic [3:0] alu_add    = 4'b0000;
    localparam logic [3:0] alu_sub    = 4'b1000;
    localparam logic [3:0] alu_sll    = 4'b0001;
    localparam logic [3:0] alu_srl    = 4'b0101;
    localparam logic [3:0] alu_sra    = 4'b1101;
    localparam logic [3:0] alu_slt    = 4'b0010;
    localparam logic [3:0] alu_sltu   = 4'b1010;
    localparam logic [3:0] alu_copy_b = 4'b0011;
    localparam logic [3:0] alu_xor    = 4'b0100;
    localparam logic [3:0] alu_or     = 4'b0110;
    localparam logic [3:0] alu_and    = 4'b0111;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch conditions, same as the branch funct3
    localparam logic [2:0] br_eq  = 3'b000;
    localparam logic [2:0] br_ne  = 3'b001;
    localparam logic [2:0] br_lt  = 3'b100;
    localparam logic [2:0] br_ge  = 3'b101;
    localparam logic [2:0] br_ltu = 3'b110;
    localparam logic [2:0] br_geu = 3'b111;

endpackage

`default_nettype wire

//--- mux_key.sv
`timescale 1ns/1ns
`default_nettype none

module mux_key #(
    parameter int nr_key   = 2,
    parameter int key_len  = 1,
    parameter int data_len = 1
) (
    output logic [data_len-1:0]                   out,
    input  wire  [key_len-1:0]                    key,
    input  wire  [nr_key*(key_len+data_len)-1:0]  lut
);

    localparam int pair_len = key_len + data_len;

    // each entry is {key, data}, data in the low bits
    always_comb begin
        out = '0;
        for (int i = 0; i < nr_key; i++) begin
            if (lut[i*pair_len+data_len +: key_len] == key) begin
                out = lut[i*pair_len +: data_len];
            end
        end
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import rv_pkg::*; #(
    parameter int width = xlen
) (
    input  wire  [width-1:0] a,
    input  wire  [width-1:0] b,
    input  wire  [3:0]       ctrl,
    output logic [width-1:0] out,
    output logic             less,
    output logic             zero
);

    localparam int sh_len = $clog2(width);

    logic             sub;
    logic [width-1:0] b_eff;
    logic [width-1:0] sum;
    logic             carry_out;
    logic             borrow;
    logic             overflow;
    logic [sh_len-1:0] shamt;
    logic             shift_left;
    logic             shift_arith;
    logic [width-1:0] sll_res;
    logic [width-1:0] srl_res;
    logic [width-1:0] sra_res;
    logic [width-1:0] shift_res;
    logic [width-1:0] and_res;
    logic [width-1:0] or_res;
    logic [width-1:0] xor_res;

    assign sub = (ctrl == alu_sub) || (ctrl == alu_slt) || (ctrl == alu_sltu);

    // a - b as a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {{width{1'b0}}, sub};
    assign borrow = sub & ~carry_out;
    assign overflow = (a[width-1] == b_eff[width-1]) && (sum[width-1] != a[width-1]);
    assign zero = ~(|sum);

    assign less = (ctrl == alu_sltu) ? borrow : (sum[width-1] ^ overflow);

    assign shamt = b[sh_len-1:0];
    assign shift_left = (ctrl == alu_sll);
    assign shift_arith = (ctrl == alu_sra);
    assign sll_res = a << shamt;
    assign srl_res = a >> shamt;
    assign sra_res = $signed(a) >>> shamt;

    mux_key #(.nr_key(3), .key_len(2), .data_len(width)) u_shift_sel (
        .out (shift_res),
        .key ({shift_left, shift_arith}),
        .lut ({
            2'b00, srl_res,
            2'b01, sra_res,
            2'b10, sll_res
        })
    );

    assign and_res = a & b;
    assign or_res  = a | b;
    assign xor_res = a ^ b;

    mux_key #(.nr_key(11), .key_len(4), .data_len(width)) u_out_sel (
        .out (out),
        .key (ctrl),
        .lut ({
            alu_add,    sum,
            alu_sub,    sum,
            alu_sll,    shift_res,
            alu_srl,    shift_res,
            alu_sra,    shift_res,
            alu_slt,    {{(width-1){1'b0}}, less},
            alu_sltu,   {{(width-1){1'b0}}, less},
            alu_copy_b, b,
            alu_xor,    xor_res,
            alu_or,     or_res,
            alu_and,    and_res
        })
    );

endmodule

`default_nettype wire

//--- alu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module alu_decode import rv_pkg::*; #(
    parameter int width = xlen
) (
    input  wire              in_valid,
    input  wire  [31:0]      instr,
    input  wire  [width-1:0] rs1_data,
    input  wire  [width-1:0] rs2_data,
    output logic             dec_valid,
    output logic [3:0]       dec_ctrl,
    output logic [width-1:0] dec_a,
    output logic [width-1:0] dec_b,
    output logic             dec_is_branch,
    output logic [2:0]       dec_cond,
    output logic             dec_illegal
);

    localparam int sh_len = $clog2(width);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [width-1:0] imm_i;
    logic [width-1:0] imm_u;
    logic [width-1:0] imm_sh;
    logic             funct7_alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = width'($signed(instr[31:20]));
    assign imm_u  = width'($signed({instr[31:12], 12'b0}));
    assign imm_sh = width'(instr[20 +: sh_len]);

    // sub and sra are the only ops with funct7 = 0100000
    assign funct7_alt = (funct7 == 7'b0100000);
    assign dec_valid = in_valid;
    assign dec_cond = funct3;

    always_comb begin
        dec_ctrl = alu_add;
        dec_a = rs1_data;
        dec_b = rs2_data;
        dec_is_branch = 1'b0;
        dec_illegal = 1'b0;
        case (opcode)
            op_reg: begin
                case (funct3)
                    f3_add_sub: dec_ctrl = funct7_alt ? alu_sub : alu_add;
                    f3_sll:     dec_ctrl = alu_sll;
                    f3_slt:     dec_ctrl = alu_slt;
                    f3_sltu:    dec_ctrl = alu_sltu;
                    f3_xor:     dec_ctrl = alu_xor;
                    f3_srl_sra: dec_ctrl = funct7_alt ? alu_sra : alu_srl;
                    f3_or:      dec_ctrl = alu_or;
                    default:    dec_ctrl = alu_and;
                endcase
                dec_illegal = !((funct7 == 7'b0) ||
                                (funct7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra)));
            end
            op_imm: begin
                dec_b = imm_i;
                case (funct3)
                    f3_add_sub: dec_ctrl = alu_add;
                    f3_sll: begin
                        dec_ctrl = alu_sll;
                        dec_b = imm_sh;
                        dec_illegal = (funct7 != 7'b0);
                    end
                    f3_slt:     dec_ctrl = alu_slt;
                    f3_sltu:    dec_ctrl = alu_sltu;
                    f3_xor:     dec_ctrl = alu_xor;
                    f3_srl_sra: begin
                        dec_ctrl = funct7_alt ? alu_sra : alu_srl;
                        dec_b = imm_sh;
                        dec_illegal = !((funct7 == 7'b0) || funct7_alt);
                    end
                    f3_or:      dec_ctrl = alu_or;
                    default:    dec_ctrl = alu_and;
                endcase
            end
            op_lui: begin
                dec_ctrl = alu_copy_b;
                dec_a = '0;
                dec_b = imm_u;
            end
            op_branch: begin
                dec_is_branch = 1'b1;
                case (funct3)
                    br_eq, br_ne:   dec_ctrl = alu_sub;
                    br_lt, br_ge:   dec_ctrl = alu_slt;
                    br_ltu, br_geu: dec_ctrl = alu_sltu;
                    default:        dec_illegal = 1'b1;
                endcase
            end
            default: dec_illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- id_ex_reg.sv
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg #(
    parameter int width = 32
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              dec_valid,
    input  wire  [3:0]       dec_ctrl,
    input  wire  [width-1:0] dec_a,
    input  wire  [width-1:0] dec_b,
    input  wire              dec_is_branch,
    input  wire  [2:0]       dec_cond,
    input  wire              dec_illegal,
    output logic             ex_valid,
    output logic [3:0]       ex_ctrl,
    output logic [width-1:0] ex_a,
    output logic [width-1:0] ex_b,
    output logic             ex_is_branch,
    output logic [2:0]       ex_cond,
    output logic             ex_illegal
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    // fields only move on a strobe
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_ctrl <= dec_ctrl;
            ex_a <= dec_a;
            ex_b <= dec_b;
            ex_is_branch <= dec_is_branch;
            ex_cond <= dec_cond;
            ex_illegal <= dec_illegal;
        end
    end

endmodule

`default_nettype wire

//--- alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec import rv_pkg::*; #(
    parameter int width = xlen
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              ex_valid,
    input  wire  [3:0]       ex_ctrl,
    input  wire  [width-1:0] ex_a,
    input  wire  [width-1:0] ex_b,
    input  wire              ex_is_branch,
    input  wire  [2:0]       ex_cond,
    input  wire              ex_illegal,
    output logic             out_valid,
    output logic [width-1:0] result,
    output logic             taken,
    output logic             illegal
);

    logic [width-1:0] alu_out;
    logic             alu_less;
    logic             alu_zero;
    logic             cond_met;

    alu #(.width(width)) u_alu (
        .a    (ex_a),
        .b    (ex_b),
        .ctrl (ex_ctrl),
        .out  (alu_out),
        .less (alu_less),
        .zero (alu_zero)
    );

    // ne and ge are the inverse of eq and lt
    always_comb begin
        case (ex_cond)
            br_eq:          cond_met = alu_zero;
            br_ne:          cond_met = ~alu_zero;
            br_lt, br_ltu:  cond_met = alu_less;
            br_ge, br_geu:  cond_met = ~alu_less;
            default:        cond_met = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result <= '0;
            taken <= 1'b0;
            illegal <= 1'b0;
        end else begin
            out_valid <= ex_valid;
            if (ex_valid) begin
                result <= ex_illegal ? '0 : alu_out;
                taken <= ex_is_branch & ~ex_illegal & cond_met;
                illegal <= ex_illegal;
            end
        end
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage import rv_pkg::*; #(
    parameter int width = xlen
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid,
    input  wire  [31:0]      instr,
    input  wire  [width-1:0] rs1_data,
    input  wire  [width-1:0] rs2_data,
    output wire              out_valid,
    output wire  [width-1:0] result,
    output wire              taken,
    output wire              illegal
);

    wire             dec_valid;
    wire [3:0]       dec_ctrl;
    wire [width-1:0] dec_a;
    wire [width-1:0] dec_b;
    wire             dec_is_branch;
    wire [2:0]       dec_cond;
    wire             dec_illegal;

    wire             ex_valid;
    wire [3:0]       ex_ctrl;
    wire [width-1:0] ex_a;
    wire [width-1:0] ex_b;
    wire             ex_is_branch;
    wire [2:0]       ex_cond;
    wire             ex_illegal;

    alu_decode #(.width(width)) u_alu_decode (
        .in_valid      (in_valid),
        .instr         (instr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .dec_valid     (dec_valid),
        .dec_ctrl      (dec_ctrl),
        .dec_a         (dec_a),
        .dec_b         (dec_b),
        .dec_is_branch (dec_is_branch),
        .dec_cond      (dec_cond),
        .dec_illegal   (dec_illegal)
    );

    id_ex_reg #(.width(width)) u_id_ex_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_valid     (dec_valid),
        .dec_ctrl      (dec_ctrl),
        .dec_a         (dec_a),
        .dec_b         (dec_b),
        .dec_is_branch (dec_is_branch),
        .dec_cond      (dec_cond),
        .dec_illegal   (dec_illegal),
        .ex_valid      (ex_valid),
        .ex_ctrl       (ex_ctrl),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_is_branch  (ex_is_branch),
        .ex_cond       (ex_cond),
        .ex_illegal    (ex_illegal)
    );

    alu_exec #(.width(width)) u_alu_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_ctrl      (ex_ctrl),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_is_branch (ex_is_branch),
        .ex_cond      (ex_cond),
        .ex_illegal   (ex_illegal),
        .out_valid    (out_valid),
        .result       (result),
        .taken        (taken),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

//--- tb_ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ex_stage;

    localparam int n_vec = 32;
    localparam int n_rand = 200;
    localparam int max_cycles = 16 + 5 + n_vec + 2 * n_rand + 50;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    wire         out_valid;
    wire  [31:0] result;
    wire         taken;
    wire         illegal;

    logic [31:0] vec_mem [0:5*n_vec-1];
    logic [15:0] lfsr;
    int          cycle;
    int          errors;
    int          checks;
    int          n_in;
    int          n_out;

    // expected outputs, oldest strobe first
    logic [31:0] q_res [$];
    logic        q_tk [$];
    logic        q_ill [$];
    int          q_cyc [$];
    string       q_name [$];

    logic [31:0] e_res;
    logic        e_tk;
    logic        e_ill;
    int          e_cyc;
    string       e_name;

    ex_stage #(.width(32)) u_ex_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .out_valid (out_valid),
        .result    (result),
        .taken     (taken),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("run stopped at the cycle limit of %0d with results still pending", cycle);
            $display("TB FAILED");
            $finish;
        end
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // returns {illegal, taken, result} by the RV32I rules
    function automatic logic [33:0] model(input logic [31:0] ins, a, b);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] opb;
        logic [4:0]  sh;
        logic [31:0] res;
        logic        tk;
        logic        bad;
        opc = ins[6:0];
        f3 = ins[14:12];
        f7 = ins[31:25];
        opb = (opc == 7'h33) ? b : {{20{ins[31]}}, ins[31:20]};
        sh = opb[4:0];
        res = '0;
        tk = 1'b0;
        bad = 1'b0;
        case (opc)
            7'h33, 7'h13: begin
                case (f3)
                    3'd0: res = (opc == 7'h33 && f7 == 7'h20) ? a - opb : a + opb;
                    3'd1: res = a << sh;
                    3'd2: res = {31'b0, $signed(a) < $signed(opb)};
                    3'd3: res = {31'b0, a < opb};
                    3'd4: res = a ^ opb;
                    3'd5: begin
                        if (f7 == 7'h20) res = $signed(a) >>> sh;
                        else res = a >> sh;
                    end
                    3'd6: res = a | opb;
                    default: res = a & opb;
                endcase
                if (opc == 7'h33)
                    bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                else if (f3 == 3'd1)
                    bad = (f7 != 7'h00);
                else if (f3 == 3'd5)
                    bad = !(f7 == 7'h00 || f7 == 7'h20);
            end
            7'h37: res = {ins[31:12], 12'b0};
            7'h63: begin
                case (f3)
                    3'd0: begin
                        res = a - b;
                        tk = (a == b);
                    end
                    3'd1: begin
                        res = a - b;
                        tk = (a != b);
                    end
                    3'd4: begin
                        res = {31'b0, $signed(a) < $signed(b)};
                        tk = res[0];
                    end
                    3'd5: begin
                        res = {31'b0, $signed(a) < $signed(b)};
                        tk = !res[0];
                    end
                    3'd6: begin
                        res = {31'b0, a < b};
                        tk = res[0];
                    end
                    3'd7: begin
                        res = {31'b0, a < b};
                        tk = !res[0];
                    end
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            res = '0;
            tk = 1'b0;
        end
        return {bad, tk, res};
    endfunction

    task automatic gen_instr(output logic [31:0] ins, output logic [31:0] a,
                             output logic [31:0] b);
        logic [31:0] kind;
        logic [31:0] f3;
        logic [31:0] alt;
        logic [31:0] regs;
        logic [31:0] mode;
        logic [31:0] imm;
        logic [6:0]  f7;
        logic [6:0]  bad_op [8];
        bad_op = '{7'h03, 7'h23, 7'h6f, 7'h67, 7'h17, 7'h73, 7'h0f, 7'h1b};
        draw_bits(3, kind);
        draw_bits(3, f3);
        draw_bits(1, alt);
        draw_bits(15, regs);
        draw_bits(32, a);
        draw_bits(32, b);
        draw_bits(2, mode);
        // bias toward equal operands and opposite signs
        if (mode[1:0] == 2'd0) begin
            b = a;
        end else if (mode[1:0] == 2'd1) begin
            a[31] = 1'b1;
            b[31] = 1'b0;
        end else if (mode[1:0] == 2'd2) begin
            a[31] = 1'b0;
            b[31] = 1'b1;
        end
        f7 = alt[0] ? 7'h20 : 7'h00;
        case (kind[2:0])
            3'd0, 3'd1: ins = {f7, regs[14:10], regs[9:5], f3[2:0], regs[4:0], 7'h33};
            3'd2, 3'd3: begin
                draw_bits(12, imm);
                if (f3[1:0] == 2'b01) imm[11:5] = f7;
                ins = {imm[11:0], regs[9:5], f3[2:0], regs[4:0], 7'h13};
            end
            3'd4: begin
                draw_bits(20, imm);
                ins = {imm[19:0], regs[4:0], 7'h37};
            end
            3'd5, 3'd6: begin
                draw_bits(12, imm);
                ins = {imm[11:5], regs[14:10], regs[9:5], f3[2:0], imm[4:0], 7'h63};
            end
            default: begin
                draw_bits(25, imm);
                ins = {imm[24:0], bad_op[f3[2:0]]};
            end
        endcase
    endtask

    task automatic send(input logic [31:0] ins, a, b, exp_res, input logic exp_tk,
                        input logic exp_ill, input string name);
        @(negedge clk);
        in_valid = 1'b1;
        instr = ins;
        rs1_data = a;
        rs2_data = b;
        q_res.push_back(exp_res);
        q_tk.push_back(exp_tk);
        q_ill.push_back(exp_ill);
        q_cyc.push_back(cycle);
        q_name.push_back(name);
        n_in++;
    endtask

    task automatic drain(input string test);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (q_res.size() != 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (q_res.size() != 0) begin
            $display("%s: no out_valid for %0d instructions", test, q_res.size());
            errors++;
            q_res.delete();
            q_tk.delete();
            q_ill.delete();
            q_cyc.delete();
            q_name.delete();
        end
    endtask

    always @(negedge clk) begin
        if (out_valid) begin
            if (q_res.size() == 0) begin
                $display("out_valid at cycle %0d with no instruction in flight", cycle);
                errors++;
            end else begin
                e_res = q_res.pop_front();
                e_tk = q_tk.pop_front();
                e_ill = q_ill.pop_front();
                e_cyc = q_cyc.pop_front();
                e_name = q_name.pop_front();
                n_out++;
                checks += 4;
                if (result !== e_res) begin
                    $display("ERR %s result expected %08h actual %08h", e_name, e_res, result);
                    errors++;
                end
                if (taken !== e_tk) begin
                    $display("ERR %s taken expected %0b actual %0b", e_name, e_tk, taken);
                    errors++;
                end
                if (illegal !== e_ill) begin
                    $display("ERR %s illegal expected %0b actual %0b", e_name, e_ill, illegal);
                    errors++;
                end
                if (cycle - e_cyc != 2) begin
                    $display("ERR %s latency expected 2 actual %0d", e_name, cycle - e_cyc);
                    errors++;
                end
            end
        end
    end

    initial begin
        int          e0;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] gap;
        logic [33:0] m;
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        rs1_data = '0;
        rs2_data = '0;
        lfsr = 16'd82;
        errors = 0;
        checks = 0;
        n_in = 0;
        n_out = 0;
        $readmemh("ex_stage_vectors.txt", vec_mem);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        @(negedge clk);
        checks += 4;
        if (out_valid !== 1'b0) begin
            $display("ERR reset out_valid expected 0 actual %0b", out_valid);
            errors++;
        end
        if (result !== 32'h0) begin
            $display("ERR reset result expected 00000000 actual %08h", result);
            errors++;
        end
        if (taken !== 1'b0 || illegal !== 1'b0) begin
            $display("ERR reset taken/illegal expected 0/0 actual %0b/%0b", taken, illegal);
            errors++;
        end
        // a legal instruction on the bus without a strobe must not come out
        instr = 32'h003100b3;
        repeat (4) @(negedge clk);
        $display("test reset: %0d errors", errors - e0);

        e0 = errors;
        for (int i = 0; i < n_vec; i++) begin
            m = model(vec_mem[5*i], vec_mem[5*i+1], vec_mem[5*i+2]);
            send(vec_mem[5*i], vec_mem[5*i+1], vec_mem[5*i+2], vec_mem[5*i+3],
                 vec_mem[5*i+4][0], m[33], $sformatf("directed[%0d]", i));
        end
        drain("directed");
        $display("test directed: %0d instructions, %0d errors", n_vec, errors - e0);

        e0 = errors;
        for (int i = 0; i < n_rand; i++) begin
            draw_bits(2, gap);
            if (gap[1:0] == 2'd0) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            gen_instr(ins, a, b);
            m = model(ins, a, b);
            send(ins, a, b, m[31:0], m[32], m[33], $sformatf("random[%0d]", i));
        end
        drain("random");
        $display("test random: %0d instructions, %0d errors", n_rand, errors - e0);

        if (n_in != n_out) begin
            $display("%0d results came out for %0d strobes", n_out, n_in);
            errors++;
        end
        $display("checks %0d, errors %0d, strobes %0d, results %0d",
                 checks, errors, n_in, n_out);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_stage_vectors.txt
// instr    rs1      rs2      result   taken
// hex, one instruction per line, result and taken two edges after the strobe
003100B3 7FFFFFFF 00000001 80000000 0
003100B3 12345678 11111111 23456789 0
403100B3 80000000 00000001 7FFFFFFF 0
403100B3 00000005 00000007 FFFFFFFE 0
003110B3 00000001 00000024 00000010 0
003120B3 80000000 00000001 00000001 0
003120B3 00000001 80000000 00000000 0
003130B3 80000000 00000001 00000000 0
003130B3 00000001 80000000 00000001 0
003140B3 FF00FF00 0F0F0F0F F00FF00F 0
003150B3 80000000 0000001F 00000001 0
403150B3 80000000 00000004 F8000000 0
003160B3 F0000000 0000000F F000000F 0
003170B3 FFFF0000 0F0F0F0F 0F0F0000 0
FFF10093 00000010 DEADBEEF 0000000F 0
FFF12093 FFFFFFFE DEADBEEF 00000001 0
FFF13093 00000005 DEADBEEF 00000001 0
80014093 00000000 DEADBEEF FFFFF800 0
7FF16093 12340000 DEADBEEF 123407FF 0
F0F17093 12345678 DEADBEEF 12345608 0
00811093 000000AB DEADBEEF 0000AB00 0
00415093 F0000000 DEADBEEF 0F000000 0
40415093 F0000000 DEADBEEF FF000000 0
ABCDE0B7 FFFFFFFF 12345678 ABCDE000 0
00310063 00000005 00000005 00000000 1
00311063 80000000 00000001 7FFFFFFF 1
00314063 80000000 00000001 00000001 1
00315063 80000000 00000001 00000001 0
00316063 80000000 00000001 00000000 0
00317063 80000000 00000001 00000000 1
00012083 00000001 00000002 00000000 0
203100B3 00000003 00000004 00000000 0

//--- ex_stage.f
rv_pkg.sv
mux_key.sv
alu.sv
alu_decode.sv
id_ex_reg.sv
alu_exec.sv
ex_stage.sv
tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    -f ex_stage.f --top-module tb_ex_stage -o tb_ex_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
